/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module dds_lab_tb -f compile.f
	./obj_dir/Vdds_lab_tb > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -qF '*** FAILED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* compile.f */
logic/dds_lab_pkg.sv
logic/key_hold_tracker.sv
logic/dds_waveform_gen.sv
logic/lfsr_modulator.sv
logic/scope_sampler.sv
logic/dds_lab_top.sv
test/dds_lab_sva.sv
test/dds_lab_tb.sv

/* logic/dds_lab_pkg.sv */
package dds_lab_pkg;

   //////////////////////////////////////////////////
   // widths and rate constants
   //////////////////////////////////////////////////
   localparam int PHASE_W       = 32;           // phase accumulator word
   localparam int SAMPLE_W      = 12;           // signed wave sample
   localparam int LUT_ADDR_W    = 6;            // quarter-sine table depth 64
   localparam int WAVE_MAX      = 2047;         // full-scale amplitude
   localparam logic [PHASE_W-1:0] LOW_RATE_INC = 32'd258; // slow carrier, about 1.5 Hz
   localparam int LFSR_W        = 5;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;
   localparam int LFSR_TICK_DIV = 2500;         // clocks per lfsr step
   localparam int SAMPLE_DIV    = 70;           // clocks per scope snapshot

   //////////////////////////////////////////////////
   // keyboard scan codes
   //////////////////////////////////////////////////
   localparam int NUM_KEYS   = 17;
   localparam int BREAK_FLAG = 7;               // event byte bit 7 marks a release

   typedef logic [6:0] key_code_t;

   // bit order follows the held-key bitmap, down arrow in bit 0
   localparam key_code_t KEY_CODES [0:NUM_KEYS-1] = '{
      7'h72,                                    // down arrow
      7'h75,                                    // up arrow
      7'h74,                                    // right arrow
      7'h6B,                                    // left arrow
      7'h29,                                    // space
      7'h3A,                                    // m
      7'h31,                                    // n
      7'h06,                                    // f2
      7'h05,                                    // f1
      7'h3E,                                    // 8
      7'h3D,                                    // 7
      7'h36,                                    // 6
      7'h2E,                                    // 5
      7'h25,                                    // 4
      7'h26,                                    // 3
      7'h1E,                                    // 2
      7'h16                                     // 1
   };

   //////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////
   typedef logic [NUM_KEYS-1:0] key_map_t;
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   typedef enum logic [1:0] {
      WAVE_SIN = 2'd0,
      WAVE_COS = 2'd1,
      WAVE_SAW = 2'd2,
      WAVE_SQU = 2'd3
   } wave_sel_t;

   typedef enum logic [1:0] {
      MOD_OOK   = 2'd0,                         // on-off keying
      MOD_TONE  = 2'd1,                         // plain carrier
      MOD_BPSK  = 2'd2,                         // phase inversion
      MOD_LEVEL = 2'd3                          // bit to level
   } mod_sel_t;

   typedef struct packed {
      sample_t sine;                            // feeds the modulator
      sample_t selected;                        // wave picked by wave_sel
   } wave_stage_t;

   typedef struct packed {
      sample_t signal;
      sample_t modulated;
   } scope_sample_t;

endpackage

/* logic/dds_lab_top.sv */
`timescale 1ns/10ps

module dds_lab_top (
   input  logic                             CLK_25MHZ,
   input  logic                             reset_from_key,
   input  logic [dds_lab_pkg::PHASE_W-1:0]  tone_inc,
   input  dds_lab_pkg::wave_sel_t           wave_sel,
   input  dds_lab_pkg::mod_sel_t            mod_sel,
   input  logic                             event_valid,
   input  logic [7:0]                       event_code,
   output dds_lab_pkg::scope_sample_t       sample,
   output logic                             sample_valid,
   output logic [dds_lab_pkg::LFSR_W-1:0]   lfsr_state,
   output dds_lab_pkg::key_map_t            key_map
);

   import dds_lab_pkg::*;

   wave_stage_t wave;                           // waveform stage output
   sample_t     modulated;
   sample_t     selected_dly;

   //////////////////////////////////////////////////
   // signal path
   //////////////////////////////////////////////////
   dds_waveform_gen u_wave (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tone_inc       (tone_inc),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .wave           (wave)
   );

   lfsr_modulator u_mod (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_sel        (mod_sel),
      .wave           (wave),
      .modulated      (modulated),
      .selected_dly   (selected_dly),
      .lfsr_state     (lfsr_state)
   );

   scope_sampler u_scope (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .modulated      (modulated),
      .selected       (selected_dly),
      .sample         (sample),
      .sample_valid   (sample_valid)
   );

   //////////////////////////////////////////////////
   // keyboard side branch
   //////////////////////////////////////////////////
   key_hold_tracker u_keys (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .key_map        (key_map)
   );

endmodule

/* logic/dds_waveform_gen.sv */
`timescale 1ns/10ps

module dds_waveform_gen (
   input  logic                              CLK_25MHZ,
   input  logic                              reset_from_key,
   input  logic [dds_lab_pkg::PHASE_W-1:0]   tone_inc,   // used only under MOD_TONE
   input  dds_lab_pkg::wave_sel_t            wave_sel,
   input  dds_lab_pkg::mod_sel_t             mod_sel,
   output dds_lab_pkg::wave_stage_t          wave
);

   import dds_lab_pkg::*;

   logic [PHASE_W-1:0]      phase;
   logic [PHASE_W-1:0]      phase_inc;
   logic [LUT_ADDR_W+1:0]   q_sin;               // top phase bits, quadrant on top
   logic [LUT_ADDR_W+1:0]   q_cos;
   sample_t                 sine_rom [0:(1<<LUT_ADDR_W)-1];
   sample_t                 sin_val;
   sample_t                 cos_val;
   sample_t                 saw_val;
   sample_t                 squ_val;
   sample_t                 sel_val;

   initial
   begin
      $readmemh("logic/sine_quarter.mem", sine_rom);
   end

   // mirror the index in quadrants 2 and 4, negate in the lower half
   function automatic sample_t fold_sine(input logic [LUT_ADDR_W+1:0] q);
      logic [LUT_ADDR_W-1:0] idx;
      sample_t               entry;
      idx   = q[LUT_ADDR_W] ? ~q[LUT_ADDR_W-1:0] : q[LUT_ADDR_W-1:0];
      entry = sine_rom[idx];
      return q[LUT_ADDR_W+1] ? -entry : entry;
   endfunction

   //////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////
   assign phase_inc = (mod_sel == MOD_TONE) ? tone_inc : LOW_RATE_INC;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;
      end
   end

   //////////////////////////////////////////////////
   // wave shaping
   //////////////////////////////////////////////////
   assign q_sin = phase[PHASE_W-1 -: LUT_ADDR_W+2];
   assign q_cos = q_sin + (LUT_ADDR_W+2)'(1 << LUT_ADDR_W);  // quarter turn ahead

   always_comb
   begin
      sin_val = fold_sine(q_sin);
      cos_val = fold_sine(q_cos);
      saw_val = sample_t'(phase[PHASE_W-1 -: SAMPLE_W]);    // ramp from top bits
      squ_val = phase[PHASE_W-1] ? -sample_t'(WAVE_MAX) : sample_t'(WAVE_MAX);

      case (wave_sel)
         WAVE_SIN: sel_val = sin_val;
         WAVE_COS: sel_val = cos_val;
         WAVE_SAW: sel_val = saw_val;
         WAVE_SQU: sel_val = squ_val;
      endcase
   end

   // wave register, one cycle behind the phase
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave <= '0;
      end
      else
      begin
         wave.sine     <= sin_val;
         wave.selected <= sel_val;
      end
   end

endmodule

/* logic/key_hold_tracker.sv */
`timescale 1ns/10ps

module key_hold_tracker (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic                event_valid,     // one-cycle strobe per key event
   input  logic [7:0]          event_code,      // make code, bit 7 set on break
   output dds_lab_pkg::key_map_t key_map
);

   import dds_lab_pkg::*;

   key_code_t event_key;
   logic      event_break;
   key_map_t  key_hit;

   assign event_key   = event_code[6:0];
   assign event_break = event_code[BREAK_FLAG];

   // one compare per tracked key, at most one can hit
   always_comb
   begin
      for (int k = 0; k < NUM_KEYS; k++)
      begin
         key_hit[k] = (event_key == KEY_CODES[k]);
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         key_map <= '0;
      end
      else if (event_valid)
      begin
         for (int k = 0; k < NUM_KEYS; k++)
         begin
            if (key_hit[k])
            begin
               key_map[k] <= ~event_break;  // make sets, break clears
            end
         end
      end
   end

endmodule

/* logic/lfsr_modulator.sv */
`timescale 1ns/10ps

module lfsr_modulator (
   input  logic                             CLK_25MHZ,
   input  logic                             reset_from_key,
   input  dds_lab_pkg::mod_sel_t            mod_sel,
   input  dds_lab_pkg::wave_stage_t         wave,
   output dds_lab_pkg::sample_t             modulated,
   output dds_lab_pkg::sample_t             selected_dly,  // aligned with modulated
   output logic [dds_lab_pkg::LFSR_W-1:0]   lfsr_state
);

   import dds_lab_pkg::*;

   logic [$clog2(LFSR_TICK_DIV)-1:0] tick_cnt;
   logic                             tick;
   logic [LFSR_W-1:0]                lfsr;
   logic                             data_bit;
   sample_t                          mod_val;

   //////////////////////////////////////////////////
   // slow tick and random bit source
   //////////////////////////////////////////////////
   assign tick = (tick_cnt == ($clog2(LFSR_TICK_DIV))'(LFSR_TICK_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt <= '0;
         lfsr     <= LFSR_SEED;
      end
      else if (tick)
      begin
         tick_cnt <= '0;
         lfsr     <= {lfsr[LFSR_W-2:0], lfsr[4] ^ lfsr[2]};  // taps 5,3
      end
      else
      begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   assign data_bit   = lfsr[0];
   assign lfsr_state = lfsr;

   //////////////////////////////////////////////////
   // modulation
   //////////////////////////////////////////////////
   always_comb
   begin
      case (mod_sel)
         MOD_OOK:   mod_val = data_bit ? wave.sine : '0;
         MOD_TONE:  mod_val = wave.sine;
         MOD_BPSK:  mod_val = data_bit ? -wave.sine : wave.sine;
         MOD_LEVEL: mod_val = data_bit ? '0 : {1'b1, {(SAMPLE_W-1){1'b0}}};  // -2048
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         modulated    <= '0;
         selected_dly <= '0;
      end
      else
      begin
         modulated    <= mod_val;
         selected_dly <= wave.selected;  // matches modulator latency
      end
   end

endmodule

/* logic/scope_sampler.sv */
`timescale 1ns/10ps

module scope_sampler (
   input  logic                        CLK_25MHZ,
   input  logic                        reset_from_key,
   input  dds_lab_pkg::sample_t        modulated,
   input  dds_lab_pkg::sample_t        selected,
   output dds_lab_pkg::scope_sample_t  sample,
   output logic                        sample_valid    // high one cycle per snapshot
);

   import dds_lab_pkg::*;

   logic [$clog2(SAMPLE_DIV)-1:0] div_cnt;
   logic                          wrap;

   assign wrap = (div_cnt == ($clog2(SAMPLE_DIV))'(SAMPLE_DIV - 1));

   // snapshot both channels on the divider wrap
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         div_cnt      <= '0;
         sample       <= '0;
         sample_valid <= 1'b0;
      end
      else
      begin
         sample_valid <= wrap;
         if (wrap)
         begin
            div_cnt          <= '0;
            sample.signal    <= selected;
            sample.modulated <= modulated;
         end
         else
         begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

endmodule

/* logic/sine_quarter.mem */
// quarter sine table, one 12-bit hex word per line
// entry i = round(2047 * sin(2*pi*(i+0.5)/256)), i = 0..63
019
04B
07E
0B0
0E2
113
145
177
1A8
1D9
20A
23A
26A
29A
2C9
2F8
327
354
382
3AF
3DB
407
432
45C
486
4AF
4D7
4FF
526
54C
571
596
5B9
5DC
5FD
61E
63E
65D
67B
698
6B4
6CF
6E9
701
719
730
745
759
76D
77F
790
79F
7AE
7BB
7C8
7D3
7DC
7E5
7EC
7F3
7F7
7FB
7FE
7FF

/* test/dds_lab_sva.sv */
`timescale 1ns/10ps

module dds_lab_sva (
   input logic                             CLK_25MHZ,
   input logic                             reset_from_key,
   input logic                             sample_valid,
   input logic [dds_lab_pkg::LFSR_W-1:0]   lfsr_state,
   input dds_lab_pkg::key_map_t            key_map
);

   import dds_lab_pkg::*;

   // one snapshot strobe per divider wrap
   a_valid_single : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      sample_valid |=> !sample_valid)
      else $error("sample_valid high on two consecutive cycles");

   // all-zero state would lock the lfsr
   a_lfsr_nonzero : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != '0)
      else $error("lfsr_state reached zero");

   a_reset_clear : assert property (@(posedge CLK_25MHZ)
      reset_from_key |=> (key_map == '0) && !sample_valid)
      else $error("key_map or sample_valid not cleared by reset");

endmodule

bind dds_lab_top dds_lab_sva u_sva (
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .sample_valid   (sample_valid),
   .lfsr_state     (lfsr_state),
   .key_map        (key_map)
);

/* test/dds_lab_tb.sv */
`timescale 1ns/10ps

module dds_lab_tb;

   import dds_lab_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int TONE_INCS  = 3;               // random increments per wave
   localparam int TONE_SNAPS = 10;
   localparam int MOD_SNAPS  = 80;              // spans two lfsr ticks from the seed
   localparam int KEY_EVENTS = 300;
   localparam int RUN_CYCLES = 4 * TONE_INCS * (TONE_SNAPS + 1) * SAMPLE_DIV
                             + 4 * (MOD_SNAPS + 1) * SAMPLE_DIV + KEY_EVENTS * 4 + 20;
   localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

   logic               CLK_25MHZ;
   logic               reset_from_key;
   logic [PHASE_W-1:0] tone_inc;
   wave_sel_t          wave_sel;
   mod_sel_t           mod_sel;
   logic               event_valid;
   logic [7:0]         event_code;
   scope_sample_t      sample;
   logic               sample_valid;
   logic [LFSR_W-1:0]  lfsr_state;
   key_map_t           key_map;

   // reference model state
   sample_t            sine_tab [0:63];
   logic               model_live = 1'b0;
   logic [PHASE_W-1:0] m_phase;
   sample_t            m_sine;
   sample_t            m_sel;
   sample_t            m_mod;
   sample_t            m_sel_dly;
   int                 m_tick;
   logic [LFSR_W-1:0]  m_lfsr;
   int                 m_div;
   scope_sample_t      m_snap;
   logic               m_valid;
   key_map_t           m_keys;

   string cur_test = "reset";
   int    err_sample = 0;
   int    err_valid = 0;
   int    err_lfsr = 0;
   int    err_keys = 0;

   dds_lab_top u_dut (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tone_inc       (tone_inc),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .sample         (sample),
      .sample_valid   (sample_valid),
      .lfsr_state     (lfsr_state),
      .key_map        (key_map)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(CLK_PERIOD / 2) CLK_25MHZ = ~CLK_25MHZ;
   end

   initial
   begin
      $readmemh("logic/sine_quarter.mem", sine_tab);
   end

   //////////////////////////////////////////////////
   // reference functions
   //////////////////////////////////////////////////
   function automatic sample_t ref_sine(input logic [7:0] q);
      logic [5:0] i;
      i = q[5:0];
      case (q[7:6])
         2'd0: return sine_tab[i];
         2'd1: return sine_tab[63 - i];            // falling half of the hump
         2'd2: return -sine_tab[i];
         default: return -sine_tab[63 - i];
      endcase
   endfunction

   function automatic sample_t ref_wave(input wave_sel_t sel, input logic [PHASE_W-1:0] ph);
      case (sel)
         WAVE_SIN: return ref_sine(ph[31:24]);
         WAVE_COS: return ref_sine(ph[31:24] + 8'd64);
         WAVE_SAW: return sample_t'(ph[31:20]);
         default: return ph[31] ? sample_t'(-WAVE_MAX) : sample_t'(WAVE_MAX);
      endcase
   endfunction

   function automatic sample_t ref_mod(input mod_sel_t sel, input sample_t sine, input logic b);
      case (sel)
         MOD_OOK: return b ? sine : sample_t'(0);
         MOD_TONE: return sine;
         MOD_BPSK: return b ? -sine : sine;
         default: return b ? sample_t'(0) : sample_t'(-2048);
      endcase
   endfunction

   function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] s);
      return {s[3:0], s[4] ^ s[2]};
   endfunction

   // later stages first so each one sees the state from before the edge
   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         m_phase = '0;
         m_sine = '0;
         m_sel = '0;
         m_mod = '0;
         m_sel_dly = '0;
         m_tick = 0;
         m_lfsr = LFSR_SEED;
         m_div = 0;
         m_snap = '0;
         m_valid = 1'b0;
         m_keys = '0;
         model_live = 1'b1;
      end
      else
      begin
         m_valid = (m_div == SAMPLE_DIV - 1);
         if (m_valid)
         begin
            m_snap.signal = m_sel_dly;
            m_snap.modulated = m_mod;
            m_div = 0;
         end
         else
         begin
            m_div++;
         end
         m_mod = ref_mod(mod_sel, m_sine, m_lfsr[0]);
         m_sel_dly = m_sel;
         if (m_tick == LFSR_TICK_DIV - 1)
         begin
            m_tick = 0;
            m_lfsr = lfsr_step(m_lfsr);
         end
         else
         begin
            m_tick++;
         end
         m_sine = ref_sine(m_phase[31:24]);
         m_sel = ref_wave(wave_sel, m_phase);
         m_phase = m_phase + ((mod_sel == MOD_TONE) ? tone_inc : LOW_RATE_INC);
         if (event_valid)
         begin
            for (int k = 0; k < NUM_KEYS; k++)
            begin
               if (event_code[6:0] == KEY_CODES[k])
               begin
                  m_keys[k] = !event_code[BREAK_FLAG];   // make sets, break clears
               end
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////
   task automatic check_sample(input string name, input scope_sample_t exp,
                               input scope_sample_t act);
      if (act !== exp)
      begin
         err_sample++;
         $display("Fail %s: sample expected %0d/%0d, actual %0d/%0d", name,
                  exp.signal, exp.modulated, act.signal, act.modulated);
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         err_valid++;
         $display("Fail %s: sample_valid expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_lfsr(input string name, input logic [LFSR_W-1:0] exp,
                             input logic [LFSR_W-1:0] act);
      if (act !== exp)
      begin
         err_lfsr++;
         $display("Fail %s: lfsr_state expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_keys(input string name, input key_map_t exp, input key_map_t act);
      if (act !== exp)
      begin
         err_keys++;
         $display("Fail %s: key_map expected %h, actual %h", name, exp, act);
      end
   endtask

   always @(negedge CLK_25MHZ)
   begin
      if (model_live)
      begin
         check_sample(cur_test, m_snap, sample);
         check_valid(cur_test, m_valid, sample_valid);
         check_lfsr(cur_test, m_lfsr, lfsr_state);
         check_keys(cur_test, m_keys, key_map);
      end
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////
   task automatic apply_reset();
      reset_from_key <= 1'b1;
      repeat (5) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
   endtask

   task automatic set_mode(input wave_sel_t w, input mod_sel_t m, input logic [PHASE_W-1:0] inc);
      @(posedge CLK_25MHZ);
      wave_sel <= w;
      mod_sel  <= m;
      tone_inc <= inc;
   endtask

   task automatic wait_snapshots(input int n);
      repeat (n)
      begin
         do
            @(negedge CLK_25MHZ);
         while (sample_valid !== 1'b1);
      end
   endtask

   task automatic send_key_event();
      int         pick;
      logic [7:0] code;
      pick = $urandom_range(0, NUM_KEYS + 3);
      if (pick < NUM_KEYS)
         code = {1'b0, KEY_CODES[pick]};
      else
         code = {1'b0, 7'($urandom())};           // mostly unknown codes
      code[BREAK_FLAG] = 1'($urandom_range(0, 1));
      @(posedge CLK_25MHZ);
      event_valid <= 1'b1;
      event_code  <= code;
      @(posedge CLK_25MHZ);
      event_valid <= 1'b0;
      repeat ($urandom_range(0, 2)) @(posedge CLK_25MHZ);
   endtask

   initial
   begin
      int unsigned seed_word;
      int          total;
      seed_word = $urandom(38160);
      reset_from_key = 1'b1;
      tone_inc = '0;
      wave_sel = WAVE_SIN;
      mod_sel = MOD_TONE;
      event_valid = 1'b0;
      event_code = '0;
      apply_reset();
      @(negedge CLK_25MHZ);
      check_lfsr("lfsr seed", LFSR_SEED, lfsr_state);

      for (int w = 0; w < 4; w++)
      begin
         for (int n = 0; n < TONE_INCS; n++)
         begin
            cur_test = $sformatf("tone wave %0d inc %0d", w, n);
            set_mode(wave_sel_t'(w), MOD_TONE, $urandom());
            wait_snapshots(TONE_SNAPS);
         end
      end

      for (int m = 0; m < 4; m++)
      begin
         cur_test = $sformatf("modulation %0d", m);
         apply_reset();                         // data bit runs 1 then 0 from the seed
         set_mode(wave_sel_t'($urandom_range(0, 3)), mod_sel_t'(m), LOW_RATE_INC);
         wait_snapshots(MOD_SNAPS);
      end

      cur_test = "key events";
      @(posedge CLK_25MHZ);
      repeat (KEY_EVENTS) send_key_event();
      cur_test = "key reset";
      apply_reset();
      @(negedge CLK_25MHZ);
      check_keys(cur_test, '0, key_map);
      repeat (4) @(posedge CLK_25MHZ);

      total = err_sample + err_valid + err_lfsr + err_keys;
      $display("errors: sample %0d, valid %0d, lfsr %0d, keys %0d", err_sample, err_valid,
               err_lfsr, err_keys);
      if (total == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // run length bound, twice the expected cycle count
   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule
